//--- Makefile
VERILATOR ?= verilator
TOP       ?= rv32v_ex_tb
RTL_TOP   ?= rv32v_ex_datapath
FLIST     ?= src.f
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --assert --timing

SOURCES := $(wildcard hdl/*.sv hdl/*.svh sim/*.sv)

.PHONY: all run lint clean

all: run

$(OBJ_DIR)/V$(TOP): $(FLIST) $(SOURCES)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(OBJ_DIR)

run: $(OBJ_DIR)/V$(TOP)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Test failed" $(LOG); then echo "Simulation reported failure, see $(LOG)"; exit 1; fi
	@if ! grep -q "Test completed successfully" $(LOG); then echo "No result in $(LOG)"; exit 1; fi

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- hdl/rv32v_ex_datapath.sv
`timescale 1ns/1ps
`include "rv32v_settings.svh"

module rv32v_ex_datapath (
    input  logic                       CLK,
    input  logic                       rst,
    input  rv32v_types_pkg::word_t     rdat1,
    input  rv32v_types_pkg::word_t     rdat2,
    input  rv32v_types_pkg::vcontrol_t vctrls,
    input  rv32v_types_pkg::vwb_t      vwb_ctrls,
    output rv32v_types_pkg::vexmem_t   vmem_in
);

    localparam int NUM_LANES = `RV32V_NUM_LANES;

    logic [`RV32V_VREG_W-1:0]                  v0;
    rv32v_types_pkg::word_t [NUM_LANES-1:0]    bankdat_src1;
    rv32v_types_pkg::word_t [NUM_LANES-1:0]    bankdat_src2;
    rv32v_types_pkg::word_t [NUM_LANES-1:0]    xbardat_src1;
    rv32v_types_pkg::word_t [NUM_LANES-1:0]    xbardat_src2;
    rv32v_types_pkg::word_t [NUM_LANES-1:0]    vopA;
    rv32v_types_pkg::word_t [NUM_LANES-1:0]    vopB;
    rv32v_types_pkg::word_t [NUM_LANES-1:0]    lane_res;
    rv32v_types_pkg::word_t                    ext_imm;
    logic [NUM_LANES-1:0]                      lane_mask;

    // 5-bit immediate is always signed
    assign ext_imm = {{(`RV32V_WORD_W-5){vctrls.vimm[4]}}, vctrls.vimm};

    // Bank k owns word k of each register
    for (genvar k = 0; k < NUM_LANES; k++) begin : g_bank
        rv32v_vector_bank vbank (
            .CLK      (CLK),
            .rst      (rst),
            .vs1      (vctrls.vs1_sel),
            .vs2      (vctrls.vs2_sel),
            .vw       (vwb_ctrls.vd),
            .vwdata   (vwb_ctrls.vwdata[k]),
            .byte_wen (vwb_ctrls.vbyte_wen[k]),
            .vdat1    (bankdat_src1[k]),
            .vdat2    (bankdat_src2[k]),
            .v0       (v0[`RV32V_WORD_W*k +: `RV32V_WORD_W])
        );
    end

    rv32v_read_xbar vsrc1_xbar (
        .bank_dat    (bankdat_src1),
        .veew        (vctrls.veew_src1),
        .bank_offset (vctrls.vbank_offset),
        .sign_ext    (vctrls.vsignext),
        .out_dat     (xbardat_src1)
    );

    // Shares offset and extension with source 1
    rv32v_read_xbar vsrc2_xbar (
        .bank_dat    (bankdat_src2),
        .veew        (vctrls.veew_src2),
        .bank_offset (vctrls.vbank_offset),
        .sign_ext    (vctrls.vsignext),
        .out_dat     (xbardat_src2)
    );

    // Operand B, immediate wins over rs1
    always_comb begin
        if (vctrls.vxin1_use_imm) begin
            vopB = {NUM_LANES{ext_imm}};
        end else if (vctrls.vxin1_use_rs1) begin
            vopB = {NUM_LANES{rdat1}};
        end else begin
            vopB = xbardat_src1;
        end
    end

    always_comb begin
        if (vctrls.vxin2_use_rs2) begin
            vopA = {NUM_LANES{rdat2}};
        end else begin
            vopA = xbardat_src2;
        end
    end

    for (genvar k = 0; k < NUM_LANES; k++) begin : g_lane
        rv32v_vfu vfu (
            .vopA (vopA[k]),
            .vopB (vopB[k]),
            .vop  (vctrls.vexec),
            .vres (lane_res[k])
        );
    end

    rv32v_mask_unit rvv_masks (
        .v0          (v0),
        .mask_enable (vctrls.vmask_en),
        .uop_num     (vctrls.vuop_num),
        .lane_active (vctrls.vlaneactive),
        .lane_mask   (lane_mask)
    );

    // EX/MEM fields, latched by the consumer
    always_comb begin
        vmem_in.vs3          = xbardat_src1;
        vmem_in.valu_res     = lane_res;
        vmem_in.vlane_mask   = lane_mask;
        vmem_in.vindexed     = vctrls.vindexed;
        vmem_in.vuop_num     = vctrls.vuop_num;
        vmem_in.vmemdren     = vctrls.vmemdren;
        vmem_in.vmemdwen     = vctrls.vmemdwen;
        vmem_in.vregwen      = vctrls.vregwen;
        vmem_in.sregwen      = vctrls.sregwen;
        vmem_in.veew         = vctrls.veew_dest;
        vmem_in.vd_sel       = vctrls.vd_sel;
        vmem_in.vbank_offset = vctrls.vbank_offset;
        vmem_in.vkeepvl      = vctrls.vkeepvl;
        // either config form updates vl
        vmem_in.vsetvl       = (vctrls.vsetvl_type != rv32v_types_pkg::NOT_CFG);
    end

endmodule

//--- hdl/rv32v_mask_unit.sv
`timescale 1ns/1ps
`include "rv32v_settings.svh"

module rv32v_mask_unit (
    input  logic [`RV32V_VREG_W-1:0]    v0,
    input  logic                        mask_enable,
    input  logic [4:0]                  uop_num,
    input  logic [`RV32V_NUM_LANES-1:0] lane_active,
    output logic [`RV32V_NUM_LANES-1:0] lane_mask
);

    localparam int NUM_LANES = `RV32V_NUM_LANES;

    // v0 bits for the elements of this uop
    logic [NUM_LANES-1:0] v0_bits;

    assign v0_bits = v0[NUM_LANES * uop_num +: NUM_LANES];

    // Unmasked ops write every active lane
    always_comb begin
        if (mask_enable) begin
            lane_mask = lane_active & v0_bits;
        end else begin
            lane_mask = lane_active;
        end
    end

endmodule

//--- hdl/rv32v_read_xbar.sv
`timescale 1ns/1ps
`include "rv32v_settings.svh"

module rv32v_read_xbar (
    input  rv32v_types_pkg::word_t [`RV32V_NUM_LANES-1:0] bank_dat,
    input  rv32v_types_pkg::veew_t                        veew,
    input  logic [1:0]                                    bank_offset,
    input  logic                                          sign_ext,
    output rv32v_types_pkg::word_t [`RV32V_NUM_LANES-1:0] out_dat
);

    localparam int NUM_LANES = `RV32V_NUM_LANES;

    logic [`RV32V_VREG_W-1:0] vreg;
    logic [7:0]               elem8  [NUM_LANES];
    logic [15:0]              elem16 [NUM_LANES];

    // Bank k holds word k of the register
    assign vreg = bank_dat;

    // Element index is offset group plus lane number
    always_comb begin
        for (int k = 0; k < NUM_LANES; k++) begin
            elem8[k]  = vreg[8 * (NUM_LANES * bank_offset + k) +: 8];
            elem16[k] = vreg[16 * (NUM_LANES * bank_offset[0] + k) +: 16];
        end
    end

    always_comb begin
        for (int k = 0; k < NUM_LANES; k++) begin
            case (veew)
                rv32v_types_pkg::EEW8: begin
                    if (sign_ext) begin
                        out_dat[k] = {{(`RV32V_WORD_W-8){elem8[k][7]}}, elem8[k]};
                    end else begin
                        out_dat[k] = {{(`RV32V_WORD_W-8){1'b0}}, elem8[k]};
                    end
                end
                rv32v_types_pkg::EEW16: begin
                    if (sign_ext) begin
                        out_dat[k] = {{(`RV32V_WORD_W-16){elem16[k][15]}}, elem16[k]};
                    end else begin
                        out_dat[k] = {{(`RV32V_WORD_W-16){1'b0}}, elem16[k]};
                    end
                end
                // full words need no extension
                default: begin
                    out_dat[k] = bank_dat[k];
                end
            endcase
        end
    end

    // Decode must never issue the reserved width
    always_comb begin
        assert (veew inside {rv32v_types_pkg::EEW8, rv32v_types_pkg::EEW16,
                             rv32v_types_pkg::EEW32})
        else $error("reserved element width on crossbar");
    end

endmodule

//--- hdl/rv32v_settings.svh
`ifndef RV32V_SETTINGS_SVH
`define RV32V_SETTINGS_SVH

// Lanes and banks are the same count
`define RV32V_NUM_LANES 4

// Architectural vector registers
`define RV32V_NUM_VREGS 32

// Register select width, log2 of the register count
`define RV32V_VSEL_W 5

// Datapath word, one per lane and bank
`define RV32V_WORD_W 32

// Full vector register, all banks side by side
`define RV32V_VREG_W (`RV32V_NUM_LANES * `RV32V_WORD_W)

`endif

//--- hdl/rv32v_types_pkg.sv
`include "rv32v_settings.svh"

package rv32v_types_pkg;

    typedef logic [`RV32V_WORD_W-1:0] word_t;

    // Element width, 2'b11 is reserved
    typedef enum logic [1:0] {
        EEW8  = 2'b00,
        EEW16 = 2'b01,
        EEW32 = 2'b10
    } veew_t;

    // Per-lane integer opcode
    typedef enum logic [2:0] {
        VADD = 3'd0,
        VSUB = 3'd1,
        VAND = 3'd2,
        VOR  = 3'd3,
        VXOR = 3'd4,
        VSLL = 3'd5,
        VSRL = 3'd6,
        VSRA = 3'd7
    } vexec_t;

    typedef enum logic [1:0] {
        NOT_CFG     = 2'b00,
        CFG_VSETVLI = 2'b01,
        CFG_VSETVL  = 2'b10
    } vsetvl_t;

    // Control word from decode, valid for one cycle
    typedef struct packed {
        logic [`RV32V_VSEL_W-1:0]   vs1_sel;
        logic [`RV32V_VSEL_W-1:0]   vs2_sel;
        logic [`RV32V_VSEL_W-1:0]   vd_sel;
        veew_t                      veew_src1;
        veew_t                      veew_src2;
        veew_t                      veew_dest;
        logic [1:0]                 vbank_offset;
        logic [4:0]                 vuop_num;
        logic                       vsignext;
        logic [4:0]                 vimm;
        logic                       vxin1_use_imm;
        logic                       vxin1_use_rs1;
        logic                       vxin2_use_rs2;
        vexec_t                     vexec;
        logic                       vmask_en;
        logic [`RV32V_NUM_LANES-1:0] vlaneactive;
        // Memory stage
        logic                       vindexed;
        logic                       vmemdren;
        logic                       vmemdwen;
        logic                       vregwen;
        logic                       sregwen;
        vsetvl_t                    vsetvl_type;
        logic                       vkeepvl;
    } vcontrol_t;

    // Write-back, one word and byte enable per bank
    typedef struct packed {
        logic [`RV32V_VSEL_W-1:0]         vd;
        word_t [`RV32V_NUM_LANES-1:0]     vwdata;
        logic [`RV32V_NUM_LANES-1:0][3:0] vbyte_wen;
    } vwb_t;

    typedef struct packed {
        word_t [`RV32V_NUM_LANES-1:0] vs3;
        word_t [`RV32V_NUM_LANES-1:0] valu_res;
        logic [`RV32V_NUM_LANES-1:0]  vlane_mask;
        logic                         vindexed;
        logic [4:0]                   vuop_num;
        logic                         vmemdren;
        logic                         vmemdwen;
        logic                         vregwen;
        logic                         sregwen;
        veew_t                        veew;
        logic [`RV32V_VSEL_W-1:0]     vd_sel;
        logic [1:0]                   vbank_offset;
        logic                         vkeepvl;
        logic                         vsetvl;
    } vexmem_t;

endpackage

//--- hdl/rv32v_vector_bank.sv
`timescale 1ns/1ps
`include "rv32v_settings.svh"

module rv32v_vector_bank (
    input  logic                     CLK,
    input  logic                     rst,
    input  logic [`RV32V_VSEL_W-1:0] vs1,
    input  logic [`RV32V_VSEL_W-1:0] vs2,
    input  logic [`RV32V_VSEL_W-1:0] vw,
    input  rv32v_types_pkg::word_t   vwdata,
    input  logic [3:0]               byte_wen,
    output rv32v_types_pkg::word_t   vdat1,
    output rv32v_types_pkg::word_t   vdat2,
    output rv32v_types_pkg::word_t   v0
);

    localparam int NUM_BYTES = `RV32V_WORD_W / 8;

    // One word slice of every vector register
    rv32v_types_pkg::word_t regs [`RV32V_NUM_VREGS];

    always_ff @(posedge CLK) begin
        if (rst) begin
            for (int r = 0; r < `RV32V_NUM_VREGS; r++) begin
                regs[r] <= '0;
            end
        end else begin
            for (int b = 0; b < NUM_BYTES; b++) begin
                if (byte_wen[b]) begin
                    regs[vw][8*b +: 8] <= vwdata[8*b +: 8];
                end
            end
        end
    end

    // Reads see the array before this edge's write
    assign vdat1 = regs[vs1];
    assign vdat2 = regs[vs2];

    // Mask register slice, always available
    assign v0 = regs[0];

    a_write_addr_known: assert property (
        @(posedge CLK) disable iff (rst)
        (|byte_wen) |-> !$isunknown(vw)
    ) else $error("bank write with unknown register select");

endmodule

//--- hdl/rv32v_vfu.sv
`timescale 1ns/1ps
`include "rv32v_settings.svh"

module rv32v_vfu (
    input  rv32v_types_pkg::word_t  vopA,
    input  rv32v_types_pkg::word_t  vopB,
    input  rv32v_types_pkg::vexec_t vop,
    output rv32v_types_pkg::word_t  vres
);

    // Shift amount is the low five bits of B
    logic [4:0] shamt;

    assign shamt = vopB[4:0];

    always_comb begin
        case (vop)
            rv32v_types_pkg::VADD: begin
                vres = vopA + vopB;
            end
            rv32v_types_pkg::VSUB: begin
                vres = vopA - vopB;
            end
            rv32v_types_pkg::VAND: begin
                vres = vopA & vopB;
            end
            rv32v_types_pkg::VOR: begin
                vres = vopA | vopB;
            end
            rv32v_types_pkg::VXOR: begin
                vres = vopA ^ vopB;
            end
            rv32v_types_pkg::VSLL: begin
                vres = vopA << shamt;
            end
            rv32v_types_pkg::VSRL: begin
                vres = vopA >> shamt;
            end
            rv32v_types_pkg::VSRA: begin
                // Arithmetic shift keeps the sign of A
                vres = $signed(vopA) >>> shamt;
            end
            default: begin
                vres = '0;
            end
        endcase
    end

endmodule

//--- sim/rv32v_ex_tb.sv
`timescale 1ns/1ps
`include "rv32v_settings.svh"

module rv32v_ex_tb;

    logic                       CLK = 1'b0;
    logic                       rst = 1'b1;
    rv32v_types_pkg::word_t     rdat1 = '0;
    rv32v_types_pkg::word_t     rdat2 = '0;
    rv32v_types_pkg::vcontrol_t vctrls = '0;
    rv32v_types_pkg::vwb_t      vwb_ctrls = '0;
    rv32v_types_pkg::vexmem_t   vmem_in;

    // Expected register contents, updated after each write edge
    logic [`RV32V_VREG_W-1:0] shadow [`RV32V_NUM_VREGS];
    integer                   seed = 32'h73ab;
    int                       check_reqs = 0;
    int                       checks_done = 0;

    rv32v_ex_datapath i_rv32v_ex_datapath (
        .CLK       (CLK),
        .rst       (rst),
        .rdat1     (rdat1),
        .rdat2     (rdat2),
        .vctrls    (vctrls),
        .vwb_ctrls (vwb_ctrls),
        .vmem_in   (vmem_in)
    );

    initial begin
        forever begin
            #50 CLK = ~CLK;
        end
    end

    initial begin
        #1_000_000;
        $display("Simulation timeout, the run did not finish in time");
        $display("Test failed");
        $fatal(1, "watchdog expired");
    end

    function automatic logic [31:0] rand32();
        return $random(seed);
    endfunction

    function automatic logic [127:0] rand128();
        return {rand32(), rand32(), rand32(), rand32()};
    endfunction

    function automatic rv32v_types_pkg::veew_t pick_eew(input logic [31:0] r);
        case (r % 3)
            0: return rv32v_types_pkg::EEW8;
            1: return rv32v_types_pkg::EEW16;
            default: return rv32v_types_pkg::EEW32;
        endcase
    endfunction

    function automatic rv32v_types_pkg::vsetvl_t pick_cfg(input logic [31:0] r);
        case (r % 3)
            0: return rv32v_types_pkg::NOT_CFG;
            1: return rv32v_types_pkg::CFG_VSETVLI;
            default: return rv32v_types_pkg::CFG_VSETVL;
        endcase
    endfunction

    // Element of lane k for one source, taken from the shadow register
    function automatic rv32v_types_pkg::word_t lane_elem(input logic [127:0] vreg,
            input rv32v_types_pkg::veew_t eew, input logic [1:0] off, input logic sext,
            input int k);
        logic [127:0] sh;
        logic [7:0]   b;
        logic [15:0]  h;
        if (eew == rv32v_types_pkg::EEW32) begin
            return vreg[32*k +: 32];
        end
        if (eew == rv32v_types_pkg::EEW16) begin
            sh = vreg >> (16 * (4 * off[0] + k));
            h = sh[15:0];
            return sext ? {{16{h[15]}}, h} : {16'h0, h};
        end
        sh = vreg >> (8 * (4 * off + k));
        b = sh[7:0];
        return sext ? {{24{b[7]}}, b} : {24'h0, b};
    endfunction

    function automatic rv32v_types_pkg::word_t lane_alu(input rv32v_types_pkg::vexec_t op,
            input rv32v_types_pkg::word_t a, input rv32v_types_pkg::word_t b);
        logic [4:0] sh;
        sh = b[4:0];
        case (op)
            rv32v_types_pkg::VADD: return a + b;
            rv32v_types_pkg::VSUB: return a + ~b + 32'd1;
            rv32v_types_pkg::VAND: return a & b;
            rv32v_types_pkg::VOR:  return a | b;
            rv32v_types_pkg::VXOR: return a ^ b;
            rv32v_types_pkg::VSLL: return a << sh;
            rv32v_types_pkg::VSRL: return a >> sh;
            // Fill the vacated top bits with the sign
            rv32v_types_pkg::VSRA: return (a >> sh) | (a[31] ? ~(32'hffffffff >> sh) : 32'h0);
            default: return 32'h0;
        endcase
    endfunction

    function automatic rv32v_types_pkg::vexmem_t expected_exmem(
            input rv32v_types_pkg::vcontrol_t c, input rv32v_types_pkg::word_t r1,
            input rv32v_types_pkg::word_t r2);
        rv32v_types_pkg::vexmem_t e;
        rv32v_types_pkg::word_t   src1;
        rv32v_types_pkg::word_t   opa;
        rv32v_types_pkg::word_t   opb;
        rv32v_types_pkg::word_t   imm;
        e = '0;
        // Two's complement value of the 5-bit field
        imm = c.vimm[4] ? (32'(c.vimm) - 32'd32) : 32'(c.vimm);
        for (int k = 0; k < 4; k++) begin
            src1 = lane_elem(shadow[c.vs1_sel], c.veew_src1, c.vbank_offset, c.vsignext, k);
            opa = c.vxin2_use_rs2 ? r2 :
                lane_elem(shadow[c.vs2_sel], c.veew_src2, c.vbank_offset, c.vsignext, k);
            opb = c.vxin1_use_imm ? imm : (c.vxin1_use_rs1 ? r1 : src1);
            e.vs3[k] = src1;
            e.valu_res[k] = lane_alu(c.vexec, opa, opb);
            e.vlane_mask[k] = c.vlaneactive[k] & (~c.vmask_en | shadow[0][4*c.vuop_num + k]);
        end
        e.vindexed = c.vindexed;
        e.vuop_num = c.vuop_num;
        e.vmemdren = c.vmemdren;
        e.vmemdwen = c.vmemdwen;
        e.vregwen = c.vregwen;
        e.sregwen = c.sregwen;
        e.veew = c.veew_dest;
        e.vd_sel = c.vd_sel;
        e.vbank_offset = c.vbank_offset;
        e.vkeepvl = c.vkeepvl;
        e.vsetvl = (c.vsetvl_type == rv32v_types_pkg::NOT_CFG) ? 1'b0 : 1'b1;
        return e;
    endfunction

    task automatic check_value(input string name, input logic [127:0] got,
            input logic [127:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
            $display("Test failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // Sample the combinational output late in the cycle
    initial begin : compare_proc
        rv32v_types_pkg::vexmem_t e;
        forever begin
            @(posedge CLK);
            #90;
            if (check_reqs != checks_done) begin
                e = expected_exmem(vctrls, rdat1, rdat2);
                check_value("vs3", 128'(vmem_in.vs3), 128'(e.vs3));
                check_value("valu_res", 128'(vmem_in.valu_res), 128'(e.valu_res));
                check_value("vlane_mask", 128'(vmem_in.vlane_mask), 128'(e.vlane_mask));
                check_value("vindexed", 128'(vmem_in.vindexed), 128'(e.vindexed));
                check_value("vuop_num", 128'(vmem_in.vuop_num), 128'(e.vuop_num));
                check_value("vmemdren", 128'(vmem_in.vmemdren), 128'(e.vmemdren));
                check_value("vmemdwen", 128'(vmem_in.vmemdwen), 128'(e.vmemdwen));
                check_value("vregwen", 128'(vmem_in.vregwen), 128'(e.vregwen));
                check_value("sregwen", 128'(vmem_in.sregwen), 128'(e.sregwen));
                check_value("veew", 128'(vmem_in.veew), 128'(e.veew));
                check_value("vd_sel", 128'(vmem_in.vd_sel), 128'(e.vd_sel));
                check_value("vbank_offset", 128'(vmem_in.vbank_offset), 128'(e.vbank_offset));
                check_value("vkeepvl", 128'(vmem_in.vkeepvl), 128'(e.vkeepvl));
                check_value("vsetvl", 128'(vmem_in.vsetvl), 128'(e.vsetvl));
                checks_done++;
            end
        end
    end

    // Request a check, wait for it, then commit any pending write
    task automatic run_cycle();
        int guard;
        int prev;
        guard = 0;
        prev = checks_done;
        check_reqs++;
        while (checks_done == prev) begin
            @(posedge CLK);
            guard++;
            if (guard > 4) begin
                $display("Timeout, the compare process did not answer a check request");
                $display("Test failed");
                $fatal(1, "compare handshake timeout");
            end
        end
        for (int k = 0; k < 4; k++) begin
            for (int b = 0; b < 4; b++) begin
                if (vwb_ctrls.vbyte_wen[k][b]) begin
                    shadow[vwb_ctrls.vd][32*k + 8*b +: 8] = vwb_ctrls.vwdata[k][8*b +: 8];
                end
            end
        end
        #5;
        vwb_ctrls.vbyte_wen = '0;
    endtask

    task automatic read_regs(input logic [4:0] a, input logic [4:0] b);
        vctrls = '0;
        vctrls.veew_src1 = rv32v_types_pkg::EEW32;
        vctrls.veew_src2 = rv32v_types_pkg::EEW32;
        vctrls.vs1_sel = a;
        vctrls.vs2_sel = b;
        run_cycle();
    endtask

    task automatic randomize_ctrl(output rv32v_types_pkg::vcontrol_t c);
        logic [31:0] r;
        logic [31:0] s;
        r = rand32();
        s = rand32();
        c.vs1_sel = r[4:0];
        c.vs2_sel = r[9:5];
        c.vd_sel = r[14:10];
        c.vbank_offset = r[16:15];
        c.vuop_num = r[21:17];
        c.vsignext = r[22];
        c.vimm = r[27:23];
        c.vxin1_use_imm = 1'b0;
        c.vxin1_use_rs1 = 1'b0;
        c.vxin2_use_rs2 = 1'b0;
        c.vexec = rv32v_types_pkg::vexec_t'(s[2:0]);
        c.vmask_en = s[3];
        c.vlaneactive = s[7:4];
        c.vindexed = s[8];
        c.vmemdren = s[9];
        c.vmemdwen = s[10];
        c.vregwen = s[11];
        c.sregwen = s[12];
        c.vkeepvl = s[13];
        c.veew_src1 = pick_eew(rand32());
        c.veew_src2 = pick_eew(rand32());
        c.veew_dest = pick_eew(rand32());
        c.vsetvl_type = pick_cfg(rand32());
    endtask

    initial begin : stimulus
        logic [31:0] r;
        for (int i = 0; i < `RV32V_NUM_VREGS; i++) begin
            shadow[i] = '0;
        end
        for (int i = 0; i < 3; i++) begin
            @(posedge CLK);
        end
        #5;
        rst = 1'b0;

        // Cleared registers, then full writes read in the same and next cycle
        for (int i = 0; i < 32; i++) begin
            read_regs(i[4:0], i[4:0]);
        end
        for (int i = 0; i < 32; i++) begin
            vwb_ctrls.vd = i[4:0];
            vwb_ctrls.vwdata = rand128();
            vwb_ctrls.vbyte_wen = 16'hffff;
            read_regs(i[4:0], 5'(31 - i));
            read_regs(i[4:0], 5'(31 - i));
        end

        // Partial byte enables
        for (int i = 0; i < 40; i++) begin
            r = rand32();
            vwb_ctrls.vd = r[4:0];
            vwb_ctrls.vwdata = rand128();
            vwb_ctrls.vbyte_wen = r[20:5];
            read_regs(r[4:0], r[4:0]);
            read_regs(r[4:0], r[25:21]);
        end

        // Narrow elements at every offset
        for (int e = 0; e < 2; e++) begin
            for (int off = 0; off < 4; off++) begin
                for (int sx = 0; sx < 2; sx++) begin
                    randomize_ctrl(vctrls);
                    vctrls.veew_src1 = (e == 0) ? rv32v_types_pkg::EEW8 : rv32v_types_pkg::EEW16;
                    vctrls.vbank_offset = off[1:0];
                    vctrls.vsignext = sx[0];
                    run_cycle();
                end
            end
        end

        // Every op with vector, immediate, rs1 and rs2 operands
        for (int op = 0; op < 8; op++) begin
            for (int src = 0; src < 8; src++) begin
                randomize_ctrl(vctrls);
                vctrls.vexec = rv32v_types_pkg::vexec_t'(op[2:0]);
                vctrls.vxin1_use_imm = (src[1:0] == 2'd1);
                vctrls.vxin1_use_rs1 = (src[1:0] == 2'd2);
                vctrls.vxin2_use_rs2 = (src[1:0] == 2'd3);
                rdat1 = rand32();
                rdat2 = rand32();
                run_cycle();
            end
        end

        // Masking against a fresh v0 every ten cycles
        for (int i = 0; i < 40; i++) begin
            if (i % 10 == 0) begin
                vwb_ctrls.vd = 5'd0;
                vwb_ctrls.vwdata = rand128();
                vwb_ctrls.vbyte_wen = 16'hffff;
                read_regs(5'd0, 5'd0);
            end
            randomize_ctrl(vctrls);
            vctrls.vmask_en = i[0];
            run_cycle();
        end

        // Forwarding with each config type
        for (int t = 0; t < 12; t++) begin
            randomize_ctrl(vctrls);
            vctrls.vsetvl_type = pick_cfg(t);
            run_cycle();
        end

        if (checks_done != check_reqs || checks_done == 0) begin
            $display("Check count mismatch, %0d requested and %0d done", check_reqs, checks_done);
            $display("Test failed");
            $fatal(1, "incomplete checking");
        end else begin
            $display("Test completed successfully");
            $finish;
        end
    end

endmodule

//--- src.f
+incdir+hdl
hdl/rv32v_types_pkg.sv
hdl/rv32v_vector_bank.sv
hdl/rv32v_read_xbar.sv
hdl/rv32v_vfu.sv
hdl/rv32v_mask_unit.sv
hdl/rv32v_ex_datapath.sv
sim/rv32v_ex_tb.sv
